// File: verilog/fpFormatPkg.sv
// binary64 number format: field widths, bias and the shared operand/result word

package fpFormatPkg;

	// ==================================================================
	// format constants
	// ==================================================================
	localparam int fpWid   = 64;		// whole word
	localparam int expWid  = 11;		// biased exponent field
	localparam int fracWid = 52;		// stored fraction, hidden bit not kept
	localparam int expBias = 1023;
	localparam int expMax  = 2047;		// inf / nan exponent

	// ieee 754 double, msb first
	typedef struct packed {
		logic sign;
		logic [expWid-1:0] exp;
		logic [fracWid-1:0] frac;
	} fp64T;

	// ==================================================================
	// operand / result word
	// ==================================================================
	// same 64 bits seen either as a plain integer or as a double;
	// which view is meaningful depends on the conversion direction
	typedef union packed {
		logic [fpWid-1:0] asInt;
		fp64T asFp;
	} cvtWordT;

endpackage

// File: verilog/cvtRegPkg.sv
// register port definitions: axi4-lite channels, register map, command and rounding types

package cvtRegPkg;

	// rounding modes, codes 5..7 fall back to nearest-even
	typedef enum logic [2:0] {
		rmNearEven = 3'd0,
		rmToZero   = 3'd1,
		rmUp       = 3'd2,		// toward +inf
		rmDown     = 3'd3,		// toward -inf
		rmAway     = 3'd4		// away from zero
	} rndModeT;

	typedef enum logic {
		intToFp = 1'b0,
		fpToInt = 1'b1
	} cvtDirT;

	// cmd register layout, bit 4 down to bit 0
	typedef struct packed {
		cvtDirT dir;
		logic isSigned;
		rndModeT rm;
	} cvtCmdT;

	// status register bits 2..0
	typedef struct packed {
		logic busy;
		logic done;			// cleared by reading status
		logic invalid;		// last f2i saturated or saw nan
	} cvtStatT;

	// ==================================================================
	// axi4-lite channels
	// ==================================================================
	typedef struct packed {
		logic awvalid;
		logic [5:0] awaddr;
		logic wvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;		// assumed all ones
		logic bready;
		logic arvalid;
		logic [5:0] araddr;
		logic rready;
	} axiReqT;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
		logic [1:0] rresp;
	} axiRspT;

	localparam logic [1:0] respOkay   = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	// register offsets
	localparam logic [5:0] regOpLo  = 6'h00;
	localparam logic [5:0] regOpHi  = 6'h04;
	localparam logic [5:0] regCmd   = 6'h08;	// write launches
	localparam logic [5:0] regStat  = 6'h0C;
	localparam logic [5:0] regResLo = 6'h10;
	localparam logic [5:0] regResHi = 6'h14;

	// round-up decision shared by both converters
	// lsb = last kept bit, rnd = first dropped bit, neg = result sign
	function automatic logic roundUp(
		rndModeT rm,
		logic lsb,
		logic rnd,
		logic sticky,
		logic neg
	);
		case (rm)
			rmToZero: roundUp = 1'b0;				// truncate
			rmUp:     roundUp = (rnd | sticky) & !neg;
			rmDown:   roundUp = (rnd | sticky) & neg;
			rmAway:   roundUp = rnd | sticky;
			default:  roundUp = rnd & (lsb | sticky);	// ties to even
		endcase
	endfunction

endpackage

// File: verilog/leadZeroCount64.sv
// leading-zero counter for a 64-bit magnitude, result registered on ce

`timescale 1ns/1ps

module leadZeroCount64 (
	input logic clk,
	input logic ce,
	input logic [fpFormatPkg::fpWid-1:0] mag,
	output logic [6:0] lzCount		// 0..64
);

	logic [6:0] cnt;

	// priority search, highest set bit wins since it is visited last
	always_comb begin
		cnt = 7'd64;					// all zero
		for (int i = 0; i < fpFormatPkg::fpWid; i++) begin
			if (mag[i])
				cnt = 7'(fpFormatPkg::fpWid - 1 - i);
		end
	end

	// staged alongside the converter's other input registers
	always_ff @(posedge clk) begin
		if (ce)
			lzCount <= cnt;
	end

endmodule

// File: verilog/intToFloat.sv
// 64-bit integer to binary64 converter, one ce stage, five rounding modes

`timescale 1ns/1ps

module intToFloat (
	input logic clk,
	input logic ce,
	input logic isSigned,			// 1 = two's complement input
	input cvtRegPkg::rndModeT rm,
	input logic [fpFormatPkg::fpWid-1:0] intIn,
	output fpFormatPkg::fp64T fpOut
);

	logic [63:0] magIn;				// |intIn| before the stage
	logic [63:0] magReg;
	logic signReg;
	logic zeroReg;
	cvtRegPkg::rndModeT rmReg;
	logic [6:0] lz;

	logic [63:0] normMag;
	logic guardBit;
	logic rndBit;
	logic stickyBit;
	logic inc;
	logic [52:0] fracSum;			// msb is the rounding carry
	logic [fpFormatPkg::expWid-1:0] expOut;

	// ==================================================================
	// input stage
	// ==================================================================
	assign magIn = (isSigned && intIn[63]) ? -intIn : intIn;	// min int stays 2^63

	always_ff @(posedge clk) begin
		if (ce) begin
			magReg  <= magIn;
			signReg <= isSigned & intIn[63];
			zeroReg <= (intIn == '0);
			rmReg   <= rm;
		end
	end

	// runs in parallel with the staging above
	leadZeroCount64 uLzc (
		.clk(clk),
		.ce(ce),
		.mag(magIn),
		.lzCount(lz)
	);

	// ==================================================================
	// normalize and round
	// ==================================================================
	always_comb begin
		normMag   = magReg << lz;		// leading one to bit 63
		guardBit  = normMag[11];		// lsb of kept fraction
		rndBit    = normMag[10];
		stickyBit = |normMag[9:0];
		inc = cvtRegPkg::roundUp(rmReg, guardBit, rndBit, stickyBit, signReg);

		// hidden bit dropped, fraction is bits 62..11
		fracSum = {1'b0, normMag[62:11]} + 53'(inc);

		// fraction overflow wraps to zero and bumps the exponent
		if (zeroReg)
			expOut = '0;
		else
			expOut = 11'(fpFormatPkg::expBias + fpFormatPkg::fpWid - 1 - int'(lz)
				+ int'(fracSum[52]));

		fpOut.sign = signReg;
		fpOut.exp  = expOut;
		fpOut.frac = fracSum[fpFormatPkg::fracWid-1:0];
	end

endmodule

// File: verilog/floatToInt.sv
// binary64 to 64-bit integer converter, one ce stage, rounding with saturation

`timescale 1ns/1ps

module floatToInt (
	input logic clk,
	input logic ce,
	input logic isSigned,
	input cvtRegPkg::rndModeT rm,
	input fpFormatPkg::fp64T fpIn,
	output logic [fpFormatPkg::fpWid-1:0] intOut,
	output logic invalidOp			// nan or out of range
);

	fpFormatPkg::fp64T fpReg;
	logic signedReg;
	cvtRegPkg::rndModeT rmReg;

	logic signed [12:0] unbExp;		// unbiased exponent
	logic [52:0] sig;				// significand with hidden bit
	logic [116:0] fixPt;			// 64 integer . 53 fraction bits
	logic [63:0] intPart;
	logic rndBit;
	logic stickyBit;
	logic inc;
	logic [64:0] magRnd;
	logic isNan;
	logic tooBig;

	always_ff @(posedge clk) begin
		if (ce) begin
			fpReg     <= fpIn;
			signedReg <= isSigned;
			rmReg     <= rm;
		end
	end

	assign isNan  = (fpReg.exp == fpFormatPkg::expMax) && (fpReg.frac != '0);
	assign unbExp = $signed({2'b00, fpReg.exp}) - $signed(13'(fpFormatPkg::expBias));
	assign sig    = {fpReg.exp != '0, fpReg.frac};	// denormals get no hidden bit

	// ==================================================================
	// align, round, saturate
	// ==================================================================
	always_comb begin
		// only exponents -1..63 can leave bits in the integer or round slot
		fixPt = '0;
		if (unbExp >= -13'sd1 && unbExp <= 13'sd63)
			fixPt = {64'd0, sig} << (unbExp + 13'sd1);
		intPart = fixPt[116:53];
		rndBit  = fixPt[52];
		stickyBit = (unbExp < -13'sd1) ? |sig : |fixPt[51:0];	// tiny and denormal

		inc    = cvtRegPkg::roundUp(rmReg, intPart[0], rndBit, stickyBit, fpReg.sign);
		magRnd = {1'b0, intPart} + 65'(inc);
		tooBig = (unbExp > 13'sd63) || magRnd[64];		// inf lands here too

		invalidOp = 1'b0;
		if (isNan) begin
			intOut    = signedReg ? {1'b0, {63{1'b1}}} : '1;
			invalidOp = 1'b1;
		end else if (!signedReg) begin
			if (fpReg.sign) begin
				intOut    = '0;					// only -0 is legal here
				invalidOp = tooBig || (magRnd != '0);
			end else if (tooBig) begin
				intOut    = '1;
				invalidOp = 1'b1;
			end else begin
				intOut = magRnd[63:0];
			end
		end else if (fpReg.sign) begin
			// down to -2^63 is representable
			if (tooBig || (magRnd[63] && magRnd[62:0] != '0)) begin
				intOut    = {1'b1, 63'd0};
				invalidOp = 1'b1;
			end else begin
				intOut = -magRnd[63:0];
			end
		end else if (tooBig || magRnd[63]) begin
			intOut    = {1'b0, {63{1'b1}}};
			invalidOp = 1'b1;
		end else begin
			intOut = magRnd[63:0];
		end
	end

endmodule

// File: verilog/cvtAxiRegs.sv
// axi4-lite slave with operand, command, status and result registers

`timescale 1ns/1ps

module cvtAxiRegs (
	input logic clk,
	input logic rstN,
	input cvtRegPkg::axiReqT axiReq,
	output cvtRegPkg::axiRspT axiRsp,
	output fpFormatPkg::cvtWordT opWord,
	output cvtRegPkg::cvtCmdT cmd,
	output logic i2fCe,
	output logic f2iCe,
	input fpFormatPkg::fp64T fpResult,
	input logic [fpFormatPkg::fpWid-1:0] intResult,
	input logic invalidOp
);

	logic wrReady;					// awready and wready together
	logic rdReady;
	logic bValid;
	logic rValid;
	logic [1:0] bResp;
	logic [1:0] rResp;
	logic [31:0] rData;
	logic [31:0] rdMux;
	logic wrFire;
	logic rdFire;
	logic wrMapped;
	logic rdMapped;
	logic cmdHit;					// accepted launch
	logic statHit;					// status read, clears done
	logic launchCe;
	logic capPend;					// result sample next edge
	cvtRegPkg::cvtStatT stat;
	fpFormatPkg::cvtWordT resWord;

	assign wrFire   = axiReq.awvalid & axiReq.wvalid & wrReady;
	assign rdFire   = axiReq.arvalid & rdReady;
	assign wrMapped = axiReq.awaddr inside {cvtRegPkg::regOpLo, cvtRegPkg::regOpHi,
		cvtRegPkg::regCmd, cvtRegPkg::regStat, cvtRegPkg::regResLo, cvtRegPkg::regResHi};
	assign rdMapped = axiReq.araddr inside {cvtRegPkg::regOpLo, cvtRegPkg::regOpHi,
		cvtRegPkg::regCmd, cvtRegPkg::regStat, cvtRegPkg::regResLo, cvtRegPkg::regResHi};
	assign cmdHit   = wrFire && axiReq.awaddr == cvtRegPkg::regCmd && !stat.busy;
	assign statHit  = rdFire && axiReq.araddr == cvtRegPkg::regStat;

	// ==================================================================
	// handshakes
	// ==================================================================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrReady <= 1'b0;
			rdReady <= 1'b0;
			bValid  <= 1'b0;
			rValid  <= 1'b0;
			bResp   <= cvtRegPkg::respOkay;
			rResp   <= cvtRegPkg::respOkay;
		end else begin
			// one-cycle ready pulses, held off while a response waits
			wrReady <= axiReq.awvalid & axiReq.wvalid & !bValid & !wrReady;
			rdReady <= axiReq.arvalid & !rValid & !rdReady;
			if (wrFire) begin
				bValid <= 1'b1;
				bResp  <= wrMapped ? cvtRegPkg::respOkay : cvtRegPkg::respSlvErr;
			end else if (axiReq.bready)
				bValid <= 1'b0;
			if (rdFire) begin
				rValid <= 1'b1;
				rResp  <= rdMapped ? cvtRegPkg::respOkay : cvtRegPkg::respSlvErr;
			end else if (axiReq.rready)
				rValid <= 1'b0;
		end
	end

	// ==================================================================
	// launch and status
	// ==================================================================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			cmd      <= '0;
			stat     <= '0;
			launchCe <= 1'b0;
			capPend  <= 1'b0;
		end else begin
			launchCe <= cmdHit;			// converter stage at N+1
			capPend  <= launchCe;		// result sampled at N+2
			if (cmdHit) begin
				cmd          <= cvtRegPkg::cvtCmdT'(axiReq.wdata[$bits(cvtRegPkg::cvtCmdT)-1:0]);
				stat.busy    <= 1'b1;
				stat.done    <= 1'b0;
				stat.invalid <= 1'b0;
			end
			if (capPend) begin
				stat.busy    <= 1'b0;
				stat.done    <= 1'b1;
				stat.invalid <= (cmd.dir == cvtRegPkg::fpToInt) & invalidOp;
			end else if (statHit)
				stat.done <= 1'b0;
		end
	end

	// ce goes only to the selected converter
	assign i2fCe = launchCe & (cmd.dir == cvtRegPkg::intToFp);
	assign f2iCe = launchCe & (cmd.dir == cvtRegPkg::fpToInt);

	// read data select
	always_comb begin
		case (axiReq.araddr)
			cvtRegPkg::regOpLo:  rdMux = opWord.asInt[31:0];
			cvtRegPkg::regOpHi:  rdMux = opWord.asInt[63:32];
			cvtRegPkg::regCmd:   rdMux = 32'(cmd);
			cvtRegPkg::regStat:  rdMux = 32'(stat);
			cvtRegPkg::regResLo: rdMux = resWord.asInt[31:0];
			cvtRegPkg::regResHi: rdMux = resWord.asInt[63:32];
			default:             rdMux = '0;
		endcase
	end

	// data registers
	always_ff @(posedge clk) begin
		if (wrFire && axiReq.awaddr == cvtRegPkg::regOpLo)
			opWord.asInt[31:0] <= axiReq.wdata;
		if (wrFire && axiReq.awaddr == cvtRegPkg::regOpHi)
			opWord.asInt[63:32] <= axiReq.wdata;
		if (capPend) begin
			if (cmd.dir == cvtRegPkg::intToFp)
				resWord.asFp <= fpResult;	// stored as a double
			else
				resWord.asInt <= intResult;
		end
		if (rdFire)
			rData <= rdMux;
	end

	assign axiRsp.awready = wrReady;
	assign axiRsp.wready  = wrReady;
	assign axiRsp.bvalid  = bValid;
	assign axiRsp.bresp   = bResp;
	assign axiRsp.arready = rdReady;
	assign axiRsp.rvalid  = rValid;
	assign axiRsp.rdata   = rData;
	assign axiRsp.rresp   = rResp;

endmodule

// File: verilog/fpConvertUnit.sv
// conversion unit top: axi4-lite register block driving int-to-double and double-to-int

`timescale 1ns/1ps

module fpConvertUnit (
	input logic clk,
	input logic rstN,
	input cvtRegPkg::axiReqT axiReq,
	output cvtRegPkg::axiRspT axiRsp
);

	fpFormatPkg::cvtWordT opWord;	// read as int or as double per direction
	cvtRegPkg::cvtCmdT cmd;
	logic i2fCe;
	logic f2iCe;
	fpFormatPkg::fp64T fpResult;
	logic [fpFormatPkg::fpWid-1:0] intResult;
	logic invalidOp;

	cvtAxiRegs uRegs (
		.clk(clk),
		.rstN(rstN),
		.axiReq(axiReq),
		.axiRsp(axiRsp),
		.opWord(opWord),
		.cmd(cmd),
		.i2fCe(i2fCe),
		.f2iCe(f2iCe),
		.fpResult(fpResult),
		.intResult(intResult),
		.invalidOp(invalidOp)
	);

	intToFloat uI2f (
		.clk(clk),
		.ce(i2fCe),
		.isSigned(cmd.isSigned),
		.rm(cmd.rm),
		.intIn(opWord.asInt),
		.fpOut(fpResult)
	);

	floatToInt uF2i (
		.clk(clk),
		.ce(f2iCe),
		.isSigned(cmd.isSigned),
		.rm(cmd.rm),
		.fpIn(opWord.asFp),
		.intOut(intResult),
		.invalidOp(invalidOp)
	);

endmodule

// File: test/fpConvertUnit_properties.sv
// register block checks: axi response hold, launch pulse shape and done timing

`timescale 1ns/1ps

module fpConvertUnit_properties (
	input logic clk,
	input logic rstN,
	input cvtRegPkg::axiReqT axiReq,
	input cvtRegPkg::axiRspT axiRsp,
	input logic launchCe,
	input cvtRegPkg::cvtStatT stat
);

	int errCount = 0;				// failed assertion count

	// responses stay up until the master takes them
	bHold: assert property (@(posedge clk) disable iff (!rstN)
		axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid)
		else begin
			$error("bvalid dropped before bready");
			errCount++;
		end
	rHold: assert property (@(posedge clk) disable iff (!rstN)
		axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid)
		else begin
			$error("rvalid dropped before rready");
			errCount++;
		end

	// single-cycle launch, never on top of a running command
	launchPulse: assert property (@(posedge clk) disable iff (!rstN)
		launchCe |=> !launchCe)
		else begin
			$error("launch longer than one cycle");
			errCount++;
		end
	launchIdle: assert property (@(posedge clk) disable iff (!rstN)
		launchCe |-> !$past(stat.busy))
		else begin
			$error("launch while busy");
			errCount++;
		end

	// stage at N+1, capture at N+2
	doneTiming: assert property (@(posedge clk) disable iff (!rstN)
		launchCe |-> ##2 $rose(stat.done))
		else begin
			$error("done not two cycles after launch");
			errCount++;
		end

endmodule

bind cvtAxiRegs fpConvertUnit_properties uProps (
	.clk(clk),
	.rstN(rstN),
	.axiReq(axiReq),
	.axiRsp(axiRsp),
	.launchCe(launchCe),
	.stat(stat)
);

// File: test/fpConvertUnitTb.sv
// testbench for the conversion unit: axi driver, random operands, reference model, checks

`timescale 1ns/1ps

module fpConvertUnitTb;

	localparam int nI2f   = 300;	// i2f operands
	localparam int nF2i   = 150;	// f2i operands
	localparam int nTrip  = 30;		// round trips, two commands each
	localparam int nCarry = 8;		// carry operands, three modes each
	localparam int nCombo = 16;		// 8 rm codes x signed/unsigned
	localparam int cmdCount = (nI2f + nF2i + 2 * nTrip) * nCombo + nCarry * 3 + 4;
	localparam int budgetNs = cmdCount * 60 * 40 + 100000;

	logic clk;
	logic rstN;
	cvtRegPkg::axiReqT axiReq;
	cvtRegPkg::axiRspT axiRsp;
	logic [31:0] rngState;

	fpConvertUnit uut (
		.clk(clk),
		.rstN(rstN),
		.axiReq(axiReq),
		.axiRsp(axiRsp)
	);

	always #20 clk = ~clk;			// 40 ns period

	// ==================================================================
	// random numbers
	// ==================================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	function automatic logic [63:0] rand64();
		return {nextRand(), nextRand()};
	endfunction

	// ==================================================================
	// reference model
	// ==================================================================
	// dropped part vs one half of the last kept unit
	function automatic int cmpHalf(input logic [63:0] rem, input logic [63:0] half);
		if (rem > half)
			return 1;
		return (rem == half) ? 0 : -1;
	endfunction

	// does the kept magnitude grow by one unit
	function automatic logic bumpUp(input logic [2:0] rm, input logic odd, input int cmp,
		input logic inexact, input logic neg);
		case (rm)
			3'd1:    return 1'b0;				// chop
			3'd2:    return inexact && !neg;
			3'd3:    return inexact && neg;
			3'd4:    return inexact;
			default: return (cmp > 0) || (cmp == 0 && odd);	// 0, 5..7
		endcase
	endfunction

	function automatic logic [63:0] expectI2f(input logic [63:0] x, input logic sgn,
		input logic [2:0] rm);
		logic neg;
		logic [63:0] mag;
		logic [63:0] kept;
		logic [63:0] rem;
		int top;
		int sh;
		neg = sgn && x[63];
		mag = neg ? -x : x;
		if (mag == 64'd0)
			return 64'd0;						// +0 always
		top = 0;
		for (int i = 0; i < 64; i++) begin
			if (mag[i])
				top = i;
		end
		if (top <= 52)
			return {neg, 11'(1023 + top), 52'(mag << (52 - top))};	// exact
		sh   = top - 52;
		kept = mag >> sh;
		rem  = mag & ((64'd1 << sh) - 64'd1);
		kept = kept + 64'(bumpUp(rm, kept[0], cmpHalf(rem, 64'd1 << (sh - 1)),
			rem != 0, neg));
		if (kept[53]) begin					// 2^53 after rounding
			kept = kept >> 1;
			top++;
		end
		return {neg, 11'(1023 + top), kept[51:0]};
	endfunction

	// returns {invalid, result}
	function automatic logic [64:0] expectF2i(input logic [63:0] w, input logic sgn,
		input logic [2:0] rm);
		logic s;
		logic [10:0] ex;
		logic [51:0] fr;
		logic [63:0] ip;
		logic [63:0] rem;
		logic [64:0] mag;
		logic big;
		logic inexact;
		int e;
		int sh;
		int cmp;
		s  = w[63];
		ex = w[62:52];
		fr = w[51:0];
		e  = int'(ex) - 1023;
		big = 1'b0;
		ip  = 64'd0;
		cmp = -1;
		inexact = 1'b0;
		if (ex == 11'h7FF && fr != 0)		// nan
			return {1'b1, sgn ? 64'h7FFF_FFFF_FFFF_FFFF : {64{1'b1}}};
		if (ex == 0)
			inexact = (fr != 0);			// zero, denormal far below half
		else if (e >= 64)
			big = 1'b1;						// infinity too
		else if (e >= 52)
			ip = {11'd0, 1'b1, fr} << (e - 52);
		else if (e >= 0) begin
			sh  = 52 - e;
			ip  = {11'd0, 1'b1, fr} >> sh;
			rem = {11'd0, 1'b1, fr} & ((64'd1 << sh) - 64'd1);
			cmp = cmpHalf(rem, 64'd1 << (sh - 1));
			inexact = (rem != 0);
		end else if (e == -1) begin
			cmp = (fr == 0) ? 0 : 1;		// value in [0.5, 1)
			inexact = 1'b1;
		end else
			inexact = 1'b1;
		mag = {1'b0, ip} + 65'(bumpUp(rm, ip[0], cmp, inexact, s));
		big = big || mag[64];
		if (!sgn) begin
			if (s)
				return {big || (mag != 0), 64'd0};
			if (big)
				return {1'b1, {64{1'b1}}};
			return {1'b0, mag[63:0]};
		end
		if (s) begin
			if (big || mag > 65'h0_8000_0000_0000_0000)
				return {1'b1, 64'h8000_0000_0000_0000};
			return {1'b0, -mag[63:0]};
		end
		if (big || mag[63])
			return {1'b1, 64'h7FFF_FFFF_FFFF_FFFF};
		return {1'b0, mag[63:0]};
	endfunction

	// ==================================================================
	// checks and axi tasks
	// ==================================================================
	task automatic checkEq(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic axiWrite(input logic [5:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int gap;
		gap = nextRand() % 4;				// bready back-pressure
		@(posedge clk);
		axiReq.awvalid <= 1'b1;
		axiReq.awaddr  <= addr;
		axiReq.wvalid  <= 1'b1;
		axiReq.wdata   <= data;
		axiReq.wstrb   <= 4'hF;
		do
			@(negedge clk);
		while (!axiRsp.awready);
		checkEq("wready with awready", 64'd1, 64'(axiRsp.wready));
		@(posedge clk);						// aw and w taken here
		axiReq.awvalid <= 1'b0;
		axiReq.wvalid  <= 1'b0;
		repeat (gap) @(posedge clk);
		axiReq.bready <= 1'b1;
		do
			@(negedge clk);
		while (!axiRsp.bvalid);
		resp = axiRsp.bresp;
		@(posedge clk);
		axiReq.bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [5:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int gap;
		gap = nextRand() % 4;				// rready back-pressure
		@(posedge clk);
		axiReq.arvalid <= 1'b1;
		axiReq.araddr  <= addr;
		do
			@(negedge clk);
		while (!axiRsp.arready);
		@(posedge clk);
		axiReq.arvalid <= 1'b0;
		repeat (gap) @(posedge clk);
		axiReq.rready <= 1'b1;
		do
			@(negedge clk);
		while (!axiRsp.rvalid);
		data = axiRsp.rdata;
		resp = axiRsp.rresp;
		@(posedge clk);
		axiReq.rready <= 1'b0;
	endtask

	// operand, command, poll status until done, then read result
	task automatic runCmd(input logic [63:0] op, input logic dir, input logic sgn,
		input logic [2:0] rm, output logic [63:0] res, output logic inv);
		logic [1:0] resp;
		logic [31:0] rd;
		logic [31:0] lo;
		axiWrite(cvtRegPkg::regOpLo, op[31:0], resp);
		checkEq("operand lo write resp", cvtRegPkg::respOkay, resp);
		axiWrite(cvtRegPkg::regOpHi, op[63:32], resp);
		checkEq("operand hi write resp", cvtRegPkg::respOkay, resp);
		axiWrite(cvtRegPkg::regCmd, 32'({dir, sgn, rm}), resp);
		checkEq("cmd write resp", cvtRegPkg::respOkay, resp);
		rd = 32'd0;
		while (!rd[1]) begin				// done bit
			axiRead(cvtRegPkg::regStat, rd, resp);
			checkEq("status read resp", cvtRegPkg::respOkay, resp);
		end
		inv = rd[0];
		axiRead(cvtRegPkg::regResLo, lo, resp);
		checkEq("result lo read resp", cvtRegPkg::respOkay, resp);
		axiRead(cvtRegPkg::regResHi, rd, resp);
		checkEq("result hi read resp", cvtRegPkg::respOkay, resp);
		res = {rd, lo};
	endtask

	// watchdog sized from the command count
	initial begin
		#(budgetNs);
		$display("Timeout: the DUT did not finish all commands within the time budget");
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	// bound protocol assertions
	always @(posedge clk) begin
		if (uut.uRegs.uProps.errCount != 0) begin
			$display("A protocol assertion on the register block failed");
			$display("TESTS FAILED");
			$fatal(1, "assertion failure");
		end
	end

	// ==================================================================
	// test sequence
	// ==================================================================
	initial begin
		logic [63:0] op;
		logic [63:0] res;
		logic [63:0] back;
		logic [64:0] expF2i;
		logic [31:0] rnd;
		logic [31:0] rd;
		logic [1:0] resp;
		logic inv;
		logic sgn;
		logic [2:0] rm;
		clk = 1'b0;
		rstN = 1'b0;
		axiReq = '0;
		rngState = 32'h2418;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;

		// integer to double over every mode and signedness
		for (int n = 0; n < nI2f; n++) begin
			case (n)
				0: op = 64'd0;
				1: op = 64'd1;
				2: op = 64'h8000_0000_0000_0000;	// most negative
				3: op = {64{1'b1}};
				default: begin
					op = rand64() >> (nextRand() % 64);	// random leading zeros
					if (nextRand() & 32'd1)
						op = ~op;				// small negatives
				end
			endcase
			for (int c = 0; c < nCombo; c++) begin
				sgn = (c >= 8);
				rm  = 3'(c % 8);
				runCmd(op, cvtRegPkg::intToFp, sgn, rm, res, inv);
				checkEq($sformatf("i2f op=%h s=%0d rm=%0d", op, sgn, rm),
					expectI2f(op, sgn, rm), res);
				checkEq("i2f invalid flag", 64'd0, inv);
			end
		end

		// 54 leading ones, rounding up carries into the exponent
		for (int k = 0; k < nCarry; k++) begin
			op = {{54{1'b1}}, 10'(nextRand())} >> k;
			for (int m = 0; m < 3; m++) begin
				rm = 3'(2 * m);					// nearest-even, up, away
				runCmd(op, cvtRegPkg::intToFp, 1'b0, rm, res, inv);
				checkEq($sformatf("carry op=%h rm=%0d", op, rm), expectI2f(op, 1'b0, rm), res);
				checkEq("carry exponent", 64'(1087 - k), 64'(res[62:52]));
				checkEq("carry fraction", 64'd0, 64'(res[51:0]));
			end
		end

		// double to integer, exponents -2..70 plus special values
		for (int n = 0; n < nF2i; n++) begin
			case (n)
				0: op = 64'h7FF8_0000_0000_0000;	// nan
				1: op = 64'h7FF0_0000_0000_0000;	// +inf
				2: op = 64'hFFF0_0000_0000_0000;	// -inf
				3: op = 64'hBFF8_0000_0000_0000;	// -1.5
				4: op = 64'h8000_0000_0000_0000;	// -0
				5: op = 64'hBFD0_0000_0000_0000;	// -0.25
				6: op = 64'h0000_0000_0000_0001;	// smallest denormal
				7: op = 64'h43E0_0000_0000_0000;	// 2^63
				8: op = 64'hC3E0_0000_0000_0000;	// -2^63
				9: op = 64'h3FE0_0000_0000_0000;	// 0.5, a tie
				default: begin
					rnd = nextRand();
					op = {rnd[0], 11'(1021 + rnd[31:1] % 73), 52'(rand64())};
				end
			endcase
			for (int c = 0; c < nCombo; c++) begin
				sgn = (c >= 8);
				rm  = 3'(c % 8);
				expF2i = expectF2i(op, sgn, rm);
				runCmd(op, cvtRegPkg::fpToInt, sgn, rm, res, inv);
				checkEq($sformatf("f2i op=%h s=%0d rm=%0d", op, sgn, rm), expF2i[63:0], res);
				checkEq($sformatf("f2i invalid op=%h s=%0d rm=%0d", op, sgn, rm),
					64'(expF2i[64]), 64'(inv));
			end
		end

		// register protocol
		axiWrite(6'h18, 32'h0000_1234, resp);
		checkEq("unmapped write resp", cvtRegPkg::respSlvErr, resp);
		axiRead(6'h20, rd, resp);
		checkEq("unmapped read resp", cvtRegPkg::respSlvErr, resp);
		runCmd(64'd7, cvtRegPkg::intToFp, 1'b1, 3'd0, res, inv);
		axiRead(cvtRegPkg::regStat, rd, resp);
		checkEq("done after second status read", 64'd0, 64'(rd[1]));
		// stray cmd on the held operand, then a full command whose result must stick
		op = 64'hFFFF_FFFF_FFFF_F801;
		axiWrite(cvtRegPkg::regCmd, 32'({cvtRegPkg::intToFp, 1'b0, 3'd2}), resp);
		checkEq("cmd write resp", cvtRegPkg::respOkay, resp);
		runCmd(op, cvtRegPkg::intToFp, 1'b0, 3'd3, res, inv);
		checkEq("rewritten cmd result", expectI2f(op, 1'b0, 3'd3), res);

		// up to 53 significant bits survive int -> double -> int
		for (int n = 0; n < nTrip; n++) begin
			for (int c = 0; c < nCombo; c++) begin
				sgn = (c >= 8);
				rm  = 3'(c % 8);
				op  = (rand64() & 64'h001F_FFFF_FFFF_FFFF) << (nextRand() % (sgn ? 11 : 12));
				if (sgn && (nextRand() & 32'd1))
					op = -op;
				runCmd(op, cvtRegPkg::intToFp, sgn, rm, res, inv);
				checkEq($sformatf("trip i2f op=%h", op), expectI2f(op, sgn, rm), res);
				runCmd(res, cvtRegPkg::fpToInt, sgn, rm, back, inv);
				checkEq($sformatf("trip back s=%0d rm=%0d", sgn, rm), op, back);
				checkEq("trip invalid flag", 64'd0, 64'(inv));
			end
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: sources.f
verilog/fpFormatPkg.sv
verilog/cvtRegPkg.sv
verilog/leadZeroCount64.sv
verilog/intToFloat.sv
verilog/floatToInt.sv
verilog/cvtAxiRegs.sv
verilog/fpConvertUnit.sv
test/fpConvertUnit_properties.sv
test/fpConvertUnitTb.sv
